// File: src/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Data and address width
`define XLEN 32

`define REG_COUNT 32
`define REG_INDEX_W 5

`define RESET_PC 32'h0000_0000 // First fetch address

// Memory access size codes
`define SIZE_BYTE 2'd0
`define SIZE_HALF 2'd1
`define SIZE_WORD 2'd2

`endif

// File: src/riscv_pkg.sv
`default_nettype none

`include "riscv_params.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_INDEX_W-1:0] reg_index_t;
    typedef logic [1:0] mem_size_t;

    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        op_imm, op, lui, auipc, branch, jal, jalr, load, store, nop
    } opcode_class_t;

    typedef enum logic [2:0] {
        f3_add  = 3'b000, // Also SUB
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101, // SRL or SRA
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } alu_funct3_t;

    typedef enum logic [2:0] {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [1:0] {
        stage_fetch, stage_fetch_wait, stage_execute, stage_mem_wait
    } stage_t;

    typedef struct packed {
        opcode_class_t op_class;
        logic [2:0]    funct3;
        logic          alt;      // Instruction bit 30
        reg_index_t    rs1;
        reg_index_t    rs2;
        reg_index_t    rd;
        word_t         imm;      // Selected and sign-extended
    } decoded_t;

    typedef struct packed {
        word_t     address;
        word_t     write_data;
        mem_size_t size;
        logic      write;
    } mem_req_t;

    typedef struct packed {
        word_t read_data;
    } mem_resp_t;

    typedef struct packed {
        word_t rd_value;
        logic  rd_write;
        word_t next_pc;
        word_t address;
    } exec_result_t;

endpackage

`default_nettype wire

// File: src/instruction_decoder.sv
`default_nettype none

module instruction_decoder
    import riscv_pkg::*;
(
    input  word_t    instruction,
    output decoded_t decoded
);

    opcode_class_t op_class;
    logic [2:0]    funct3;
    word_t         imm_i;
    word_t         imm_s;
    word_t         imm_b;
    word_t         imm_u;
    word_t         imm_j;

    assign funct3 = instruction[14:12];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // Unsupported funct3 values fall back to nop
    always_comb begin
        case (instruction[6:0])
            opc_op_imm: op_class = op_imm;
            opc_op:     op_class = op;
            opc_lui:    op_class = lui;
            opc_auipc:  op_class = auipc;
            opc_branch: op_class = (funct3[2:1] == 2'b01) ? nop : branch;
            opc_jal:    op_class = jal;
            opc_jalr:   op_class = (funct3 == 3'b000) ? jalr : nop;
            opc_load:   op_class = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                                   ? load : nop;
            opc_store:  op_class = (funct3 inside {3'b000, 3'b001, 3'b010}) ? store : nop;
            default:    op_class = nop; // SYSTEM, MISC-MEM, unknown
        endcase
    end

    always_comb begin
        decoded.op_class = op_class;
        decoded.funct3   = funct3;
        decoded.alt      = instruction[30];
        decoded.rs1      = instruction[19:15];
        decoded.rs2      = instruction[24:20];
        decoded.rd       = instruction[11:7];
        case (op_class)
            op_imm, jalr, load: decoded.imm = imm_i;
            store:              decoded.imm = imm_s;
            branch:             decoded.imm = imm_b;
            lui, auipc:         decoded.imm = imm_u;
            jal:                decoded.imm = imm_j;
            default:            decoded.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/register_file.sv
`default_nettype none

`include "riscv_params.svh"

module register_file
    import riscv_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  reg_index_t rs1_index,
    input  reg_index_t rs2_index,
    output word_t      rs1_value,
    output word_t      rs2_value,
    input  logic       write_enable,
    input  reg_index_t write_index,
    input  word_t      write_value
);

    word_t registers [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && (write_index != '0)) begin // x0 stays zero
            registers[write_index] <= write_value;
        end
    end

    assign rs1_value = registers[rs1_index];
    assign rs2_value = registers[rs2_index];

endmodule

`default_nettype wire

// File: src/execute_unit.sv
`default_nettype none

module execute_unit
    import riscv_pkg::*;
(
    input  decoded_t     decoded,
    input  word_t        pc,
    input  word_t        rs1_value,
    input  word_t        rs2_value,
    output exec_result_t result
);

    word_t alu_b;
    word_t alu_value;
    word_t link_pc;
    word_t jump_base;
    logic  take_branch;

    assign alu_b     = (decoded.op_class == op) ? rs2_value : decoded.imm;
    assign link_pc   = pc + 32'd4;
    assign jump_base = rs1_value + decoded.imm; // Also the load/store address

    always_comb begin
        case (alu_funct3_t'(decoded.funct3))
            f3_add:  alu_value = (decoded.op_class == op && decoded.alt)
                                 ? rs1_value - alu_b : rs1_value + alu_b;
            f3_sll:  alu_value = rs1_value << alu_b[4:0];
            f3_slt:  alu_value = word_t'($signed(rs1_value) < $signed(alu_b));
            f3_sltu: alu_value = word_t'(rs1_value < alu_b);
            f3_xor:  alu_value = rs1_value ^ alu_b;
            f3_sr:   alu_value = decoded.alt ? word_t'($signed(rs1_value) >>> alu_b[4:0])
                                             : rs1_value >> alu_b[4:0];
            f3_or:   alu_value = rs1_value | alu_b;
            default: alu_value = rs1_value & alu_b;
        endcase
    end

    always_comb begin
        case (branch_funct3_t'(decoded.funct3))
            f3_beq:  take_branch = rs1_value == rs2_value;
            f3_bne:  take_branch = rs1_value != rs2_value;
            f3_blt:  take_branch = $signed(rs1_value) < $signed(rs2_value);
            f3_bge:  take_branch = $signed(rs1_value) >= $signed(rs2_value);
            f3_bltu: take_branch = rs1_value < rs2_value;
            f3_bgeu: take_branch = rs1_value >= rs2_value;
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        result.rd_value = alu_value;
        result.rd_write = 1'b0;
        result.next_pc  = link_pc;
        result.address  = jump_base;
        case (decoded.op_class)
            op_imm, op: result.rd_write = 1'b1;
            lui: begin
                result.rd_value = decoded.imm;
                result.rd_write = 1'b1;
            end
            auipc: begin
                result.rd_value = pc + decoded.imm;
                result.rd_write = 1'b1;
            end
            jal: begin
                result.rd_value = link_pc;
                result.rd_write = 1'b1;
                result.next_pc  = pc + decoded.imm;
            end
            jalr: begin
                result.rd_value = link_pc;
                result.rd_write = 1'b1;
                result.next_pc  = jump_base & ~word_t'(1);
            end
            branch: begin
                if (take_branch) begin
                    result.next_pc = pc + decoded.imm;
                end
            end
            default: ; // Loads write through the data response
        endcase
    end

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
`default_nettype none

`include "riscv_params.svh"

module load_store_unit
    import riscv_pkg::*;
(
    input  decoded_t  decoded,
    input  word_t     rs2_value,
    input  word_t     load_data,
    output word_t     store_data,
    output mem_size_t store_size,
    output word_t     load_value
);

    // funct3[1:0] encodes the size for loads as well
    always_comb begin
        case (decoded.funct3[1:0])
            2'b00: begin
                store_size = `SIZE_BYTE;
                store_data = {24'b0, rs2_value[7:0]};
            end
            2'b01: begin
                store_size = `SIZE_HALF;
                store_data = {16'b0, rs2_value[15:0]};
            end
            default: begin
                store_size = `SIZE_WORD;
                store_data = rs2_value;
            end
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            3'b000:  load_value = {{24{load_data[7]}}, load_data[7:0]};   // LB
            3'b001:  load_value = {{16{load_data[15]}}, load_data[15:0]}; // LH
            3'b100:  load_value = {24'b0, load_data[7:0]};                // LBU
            3'b101:  load_value = {16'b0, load_data[15:0]};               // LHU
            default: load_value = load_data;
        endcase
    end

endmodule

`default_nettype wire

// File: src/core_control.sv
`default_nettype none

`include "riscv_params.svh"

module core_control
    import riscv_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  decoded_t     decoded,
    input  exec_result_t result,
    input  word_t        store_data,
    input  mem_size_t    store_size,
    input  word_t        load_value,
    output word_t        instruction,
    output word_t        pc,
    output logic         rd_write,
    output reg_index_t   rd_index,
    output word_t        rd_value,
    output logic         mem_req_valid,
    output mem_req_t     mem_req,
    input  logic         mem_resp_valid,
    input  mem_resp_t    mem_resp
);

    stage_t stage;
    logic   is_mem_op;
    logic   load_done;

    function automatic mem_req_t fetch_request(word_t address);
        mem_req_t req;
        req.address    = address;
        req.write_data = '0;
        req.size       = `SIZE_WORD;
        req.write      = 1'b0;
        return req;
    endfunction

    assign is_mem_op = (decoded.op_class == load) || (decoded.op_class == store);
    assign load_done = (stage == stage_mem_wait) && mem_resp_valid
                       && (decoded.op_class == load);

    // Register write port
    assign rd_write = ((stage == stage_execute) && result.rd_write) || load_done;
    assign rd_index = decoded.rd;
    assign rd_value = (stage == stage_mem_wait) ? load_value : result.rd_value;

    always_ff @(posedge clock) begin
        if (reset) begin
            stage         <= stage_fetch;
            pc            <= `RESET_PC;
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= 1'b0;
            case (stage)
                stage_fetch: begin // Only after reset
                    mem_req_valid <= 1'b1;
                    stage         <= stage_fetch_wait;
                end
                stage_fetch_wait: begin
                    if (mem_resp_valid) begin
                        stage <= stage_execute;
                    end
                end
                stage_execute: begin
                    mem_req_valid <= 1'b1; // Data access or next fetch
                    if (is_mem_op) begin
                        stage <= stage_mem_wait;
                    end else begin
                        pc    <= result.next_pc;
                        stage <= stage_fetch_wait;
                    end
                end
                stage_mem_wait: begin
                    if (mem_resp_valid) begin
                        mem_req_valid <= 1'b1;
                        pc            <= result.next_pc; // PC plus 4
                        stage         <= stage_fetch_wait;
                    end
                end
            endcase
        end
    end

    // Request payload follows the pulse logic above
    always_ff @(posedge clock) begin
        case (stage)
            stage_fetch: mem_req <= fetch_request(pc);
            stage_fetch_wait: begin
                if (mem_resp_valid) begin
                    instruction <= mem_resp.read_data;
                end
            end
            stage_execute: begin
                if (is_mem_op) begin
                    mem_req <= '{address: result.address, write_data: store_data,
                                 size: store_size, write: decoded.op_class == store};
                end else begin
                    mem_req <= fetch_request(result.next_pc);
                end
            end
            stage_mem_wait: begin
                if (mem_resp_valid) begin
                    mem_req <= fetch_request(result.next_pc);
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/riscv_core.sv
`default_nettype none

module riscv_core
    import riscv_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_resp_valid,
    input  mem_resp_t mem_resp
);

    word_t        instruction;
    decoded_t     decoded;
    exec_result_t result;
    word_t        rs1_value;
    word_t        rs2_value;
    word_t        store_data;
    mem_size_t    store_size;
    word_t        load_value;
    logic         rd_write;
    reg_index_t   rd_index;
    word_t        rd_value;
    word_t        pc;

    core_control control (
        .clock          (clock),
        .reset          (reset),
        .decoded        (decoded),
        .result         (result),
        .store_data     (store_data),
        .store_size     (store_size),
        .load_value     (load_value),
        .instruction    (instruction),
        .pc             (pc),
        .rd_write       (rd_write),
        .rd_index       (rd_index),
        .rd_value       (rd_value),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp)
    );

    instruction_decoder decoder (
        .instruction (instruction),
        .decoded     (decoded)
    );

    register_file registers (
        .clock        (clock),
        .reset        (reset),
        .rs1_index    (decoded.rs1),
        .rs2_index    (decoded.rs2),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .write_enable (rd_write),
        .write_index  (rd_index),
        .write_value  (rd_value)
    );

    execute_unit execute (
        .decoded   (decoded),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .result    (result)
    );

    load_store_unit lsu (
        .decoded    (decoded),
        .rs2_value  (rs2_value),
        .load_data  (mem_resp.read_data),
        .store_data (store_data),
        .store_size (store_size),
        .load_value (load_value)
    );

endmodule

`default_nettype wire

// File: sim/riscv_core_assert.sv
`default_nettype none

module riscv_core_assert
    import riscv_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     mem_req_valid,
    input mem_req_t mem_req,
    input logic     mem_resp_valid,
    input stage_t   stage
);

    timeunit 1ns;
    timeprecision 100ps;

    logic outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req_valid) begin
            outstanding <= 1'b1;
        end else if (mem_resp_valid) begin
            outstanding <= 1'b0;
        end
    end

    no_request_in_reset: assert property (@(posedge clock) reset |=> !mem_req_valid)
        else $error("request pulse while in reset");

    one_outstanding: assert property (@(posedge clock) disable iff (reset)
        outstanding |-> !mem_req_valid)
        else $error("new request before the previous response");

    // A pulse seen in fetch_wait is an instruction fetch
    fetch_aligned: assert property (@(posedge clock) disable iff (reset)
        (mem_req_valid && stage == stage_fetch_wait) |-> mem_req.address[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

`default_nettype wire

// File: sim/riscv_core_tb.sv
`default_nettype none

`include "riscv_params.svh"

module riscv_core_tb
    import riscv_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    logic      clock;
    logic      reset;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_resp_valid;
    mem_resp_t mem_resp;

    word_t    memory [256];
    mem_req_t expected [$];
    int       total_requests;
    int       matched;
    int       seed = 48;
    logic     loaded;
    logic     done;

    riscv_core DUT (
        .clock          (clock),
        .reset          (reset),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp)
    );

    bind core_control riscv_core_assert handshake_checks (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expect_value);
        if (actual !== expect_value) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, actual,
                     expect_value);
            stop_with_failure();
        end
    endtask

    // P lines fill the program image, R lines queue the expected requests
    task automatic load_golden();
        int       fd;
        int       code;
        int       write_flag;
        int       size;
        string    line;
        string    tag;
        word_t    address;
        word_t    data;
        mem_req_t entry;
        for (int i = 0; i < 256; i++) begin
            memory[i] = 32'h5A5A_0000 | (i << 2); // Unused words hold their address
        end
        fd = $fopen("sim/core_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file sim/core_golden.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            tag = "";
            if (code > 0) begin
                code = $sscanf(line, "%s", tag);
            end
            if (tag == "P") begin
                code = $sscanf(line, "P %h %h", address, data);
                memory[address[9:2]] = data;
            end else if (tag == "R") begin
                code = $sscanf(line, "R %h %d %d %h", address, write_flag, size, data);
                entry.address    = address;
                entry.write      = write_flag[0];
                entry.size       = size[1:0];
                entry.write_data = data;
                expected.push_back(entry);
            end
        end
        $fclose(fd);
        total_requests = expected.size();
    endtask

    task automatic check_request(mem_req_t got);
        mem_req_t want;
        if (matched == 0) begin
            check_value("first fetch address", got.address, `RESET_PC);
        end
        want = expected.pop_front();
        check_value("mem_req.address", got.address, want.address);
        check_value("mem_req.write", {31'b0, got.write}, {31'b0, want.write});
        check_value("mem_req.size", {30'b0, got.size}, {30'b0, want.size});
        if (want.write) begin // Read requests carry no meaningful data
            check_value("mem_req.write_data", got.write_data, want.write_data);
        end
        matched = matched + 1;
    endtask

    task automatic write_memory(mem_req_t req);
        int lane;
        lane = int'(req.address[1:0]);
        case (req.size)
            `SIZE_BYTE: memory[req.address[9:2]][8*lane +: 8] = req.write_data[7:0];
            `SIZE_HALF: memory[req.address[9:2]][8*lane +: 16] = req.write_data[15:0];
            default:    memory[req.address[9:2]] = req.write_data;
        endcase
    endtask

    initial begin : memory_model
        mem_req_t got;
        int       delay;
        wait (loaded);
        forever begin
            @(posedge clock);
            if (!reset && mem_req_valid) begin
                got = mem_req;
                if (expected.size() > 0) begin
                    check_request(got);
                end
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(posedge clock);
                if (got.write) begin
                    write_memory(got);
                    mem_resp <= '0;
                end else begin
                    mem_resp.read_data <= memory[got.address[9:2]] >> (8 * got.address[1:0]);
                end
                mem_resp_valid <= 1'b1;
                @(posedge clock);
                mem_resp_valid <= 1'b0;
                if (matched == total_requests) begin
                    done = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (total_requests * 40) @(posedge clock);
        $display("Timeout: the core did not issue all expected requests in time");
        stop_with_failure();
    end

    initial begin
        reset          <= 1'b1;
        mem_resp_valid <= 1'b0;
        mem_resp       <= '0;
        matched        = 0;
        loaded         = 1'b0;
        done           = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        wait (done);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/core_golden.txt
# P <byte address hex> <instruction word hex>
# R <address hex> <write 0/1> <size 0=byte 1=half 2=word> <write data hex>
P 00000000 FFB00093
P 00000004 4010D113
P 00000008 401101B3
P 0000000C 0011B233
P 00000010 004192B3
P 00000014 10502023
P 00000018 10101223
P 0000001C 10200323
P 00000020 10401303
P 00000024 10604383
P 00000028 00730433
P 0000002C 10802423
P 00000030 10600483
P 00000034 10405503
P 00000038 40A485B3
P 0000003C 10B02623
P 00000040 00700013
P 00000044 10002823
P 00000048 0000C463
P 00000050 0000E463
P 00000054 00419463
P 0000005C 00418463
P 00000060 00125463
P 00000068 00127463
P 0000006C 0080066F
P 00000074 009606E7
P 00000078 12345737
P 0000007C 00001797
P 00000080 00F70733
P 00000084 00C6C6B3
P 00000088 10E02A23
P 0000008C 10D02C23
P 00000090 0000006F
R 00000000 0 2 00000000
R 00000004 0 2 00000000
R 00000008 0 2 00000000
R 0000000C 0 2 00000000
R 00000010 0 2 00000000
R 00000014 0 2 00000000
R 00000100 1 2 00000004
R 00000018 0 2 00000000
R 00000104 1 1 0000FFFB
R 0000001C 0 2 00000000
R 00000106 1 0 000000FD
R 00000020 0 2 00000000
R 00000104 0 1 00000000
R 00000024 0 2 00000000
R 00000106 0 0 00000000
R 00000028 0 2 00000000
R 0000002C 0 2 00000000
R 00000108 1 2 000000F8
R 00000030 0 2 00000000
R 00000106 0 0 00000000
R 00000034 0 2 00000000
R 00000104 0 1 00000000
R 00000038 0 2 00000000
R 0000003C 0 2 00000000
R 0000010C 1 2 FFFF0002
R 00000040 0 2 00000000
R 00000044 0 2 00000000
R 00000110 1 2 00000000
R 00000048 0 2 00000000
R 00000050 0 2 00000000
R 00000054 0 2 00000000
R 0000005C 0 2 00000000
R 00000060 0 2 00000000
R 00000068 0 2 00000000
R 0000006C 0 2 00000000
R 00000074 0 2 00000000
R 00000078 0 2 00000000
R 0000007C 0 2 00000000
R 00000080 0 2 00000000
R 00000084 0 2 00000000
R 00000088 0 2 00000000
R 00000114 1 2 1234607C
R 0000008C 0 2 00000000
R 00000118 1 2 00000008
R 00000090 0 2 00000000
R 00000090 0 2 00000000

// File: sources.f
+incdir+src
src/riscv_pkg.sv
src/instruction_decoder.sv
src/register_file.sv
src/execute_unit.sv
src/load_store_unit.sv
src/core_control.sv
src/riscv_core.sv
sim/riscv_core_assert.sv
sim/riscv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module riscv_core_tb -o riscv_core_sim &&
./obj_dir/riscv_core_sim | tee /dev/stderr | grep -qF "All tests passed!" &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }
